// File: common/usb_rx_pkg.sv
// ==============================
// Shared constants, enums and structs
// for the USB receive path
// ==============================

package usb_rx_pkg;

	// Sync pattern KJKJKJKK after NRZI decode, assembled LSB first
	localparam logic [7:0] SYNC_BYTE = 8'h80;

	// APB register map
	localparam logic [7:0] STATUS_ADDR = 8'h00;
	localparam logic [7:0] DATA_ADDR   = 8'h04;
	localparam logic [7:0] COUNT_ADDR  = 8'h08;

	// Legal PID codes, lower nibble as sent on the bus
	typedef enum logic [3:0] {
		PID_OUT   = 4'b0001,
		PID_IN    = 4'b1001,
		PID_SOF   = 4'b0101,
		PID_SETUP = 4'b1101,
		PID_DATA0 = 4'b0011,
		PID_DATA1 = 4'b1011,
		PID_ACK   = 4'b0010,
		PID_NAK   = 4'b1010,
		PID_STALL = 4'b1110
	} usb_pid_e;

	// Packet controller states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SYNC,
		ST_PID,
		ST_DATA,
		ST_DONE,
		ST_ERROR
	} rx_state_e;

	typedef struct packed {
		logic d_edge;
		logic eop;
		logic bit_val;
	} line_evt_t;

	// One FIFO word, is_pid lands on bit 8 of a DATA read
	typedef struct packed {
		logic       is_pid;
		logic [7:0] data;
	} rx_entry_t;

endpackage

// File: rtl/usb_line_sync.sv
// ==============================
// Input synchronizer for D+ and D-
// with edge and SE0 detection
// ==============================
`timescale 1ns/1ps

module usb_line_sync
	import usb_rx_pkg::*;
(
	input  logic      clk,
	input  logic      n_rst,
	input  logic      d_plus,
	input  logic      d_minus,
	output line_evt_t evt
);

	logic dp_meta;
	logic dp_sync;
	logic dp_prev;
	logic dm_meta;
	logic dm_sync;
	logic eop_q;

	// Two flop stages per line, idle J is D+ high and D- low
	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
		begin
			dp_meta <= 1'b1;
			dp_sync <= 1'b1;
			dp_prev <= 1'b1;
			dm_meta <= 1'b0;
			dm_sync <= 1'b0;
		end
		else
		begin
			dp_meta <= d_plus;
			dp_sync <= dp_meta;
			dp_prev <= dp_sync;
			dm_meta <= d_minus;
			dm_sync <= dm_meta;
		end
	end

	// SE0 on both lines
	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
			eop_q <= 1'b0;
		else
			eop_q <= !dp_sync && !dm_sync;
	end

	assign evt.d_edge  = dp_sync ^ dp_prev;
	assign evt.eop     = eop_q;
	assign evt.bit_val = dp_sync;

endmodule

// File: usb_timer/usb_rx_timer.sv
// ==============================
// Receive bit timing, bit-stuff
// hold and byte counting
// ==============================
`timescale 1ns/1ps

module usb_rx_timer
	import usb_rx_pkg::*;
#(
	parameter int CLKS_PER_BIT = 8
)
(
	input  logic      clk,
	input  logic      n_rst,
	input  line_evt_t evt,
	input  logic      receiving,
	output logic      shift_enable,
	output logic      rx_hold,
	output logic      byte_received
);

	localparam int PW = $clog2(CLKS_PER_BIT);
	localparam logic [PW-1:0] MID_PHASE = PW'(CLKS_PER_BIT / 2);
	localparam logic [PW-1:0] LAST_PHASE = PW'(CLKS_PER_BIT - 1);

	logic [PW-1:0] phase;
	logic [2:0]    run_cnt;
	logic [2:0]    bit_cnt;
	logic          edge_seen;

	// Phase restarts on each line edge so the strobe stays mid-bit
	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
			phase <= '0;
		else if (evt.d_edge)
			phase <= PW'(1);
		else if (phase == LAST_PHASE)
			phase <= '0;
		else
			phase <= phase + 1'b1;
	end

	assign shift_enable = receiving && (phase == MID_PHASE);

	// Seventh bit after six ones is the stuffed zero
	assign rx_hold = shift_enable && (run_cnt == 3'd6);

	// Ones counted as strobes with no edge since the last strobe
	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
		begin
			edge_seen <= 1'b0;
			run_cnt   <= '0;
		end
		else
		begin
			if (evt.d_edge)
				edge_seen <= 1'b1;
			else if (shift_enable)
				edge_seen <= 1'b0;

			if (!receiving || rx_hold)
				run_cnt <= '0;
			else if (shift_enable)
				run_cnt <= edge_seen ? 3'd0 : run_cnt + 3'd1;
		end
	end

	// Byte flag lines up with the shifter holding all eight bits
	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
		begin
			bit_cnt       <= '0;
			byte_received <= 1'b0;
		end
		else
		begin
			byte_received <= 1'b0;
			if (!receiving)
				bit_cnt <= '0;
			else if (shift_enable && !rx_hold)
			begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7)
					byte_received <= 1'b1;
			end
		end
	end

	// The held bit is the stuffed zero, so the line has toggled before it
	hold_on_strobe: assert property (@(posedge clk) disable iff (!n_rst)
		rx_hold |-> shift_enable && edge_seen);

	byte_single_cycle: assert property (@(posedge clk) disable iff (!n_rst)
		byte_received |=> !byte_received);

endmodule

// File: rtl/usb_rx_shifter.sv
// ==============================
// NRZI decoder and receive
// shift register
// ==============================
`timescale 1ns/1ps

module usb_rx_shifter
	import usb_rx_pkg::*;
(
	input  logic       clk,
	input  logic       n_rst,
	input  line_evt_t  evt,
	input  logic       shift_enable,
	input  logic       rx_hold,
	input  logic       receiving,
	output logic [7:0] rx_byte
);

	logic       last_level;
	logic       decoded;
	logic [7:0] shreg;

	// No transition means a one
	assign decoded = ~(evt.bit_val ^ last_level);

	// Level of the previous bit, back to J between packets
	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
			last_level <= 1'b1;
		else if (!receiving)
			last_level <= 1'b1;
		else if (shift_enable)
			last_level <= evt.bit_val;
	end

	// LSB arrives first, so shift in from the top
	always_ff @(posedge clk)
	begin
		if (shift_enable && !rx_hold)
			shreg <= {decoded, shreg[7:1]};
	end

	assign rx_byte = shreg;

endmodule

// File: rtl/usb_rx_ctrl.sv
// ==============================
// Packet FSM, sync and PID checks,
// FIFO push and error reporting
// ==============================
`timescale 1ns/1ps

module usb_rx_ctrl
	import usb_rx_pkg::*;
(
	input  logic       clk,
	input  logic       n_rst,
	input  line_evt_t  evt,
	input  logic       byte_received,
	input  logic [7:0] rx_byte,
	input  logic       full,
	output logic       receiving,
	output rx_entry_t  push_entry,
	output logic       push_valid,
	output logic       err_pulse,
	output logic       pkt_done
);

	rx_state_e state;
	logic      pid_legal;
	logic      pid_ok;

	always_comb
	begin
		case (rx_byte[3:0])
			PID_OUT, PID_IN, PID_SOF, PID_SETUP, PID_DATA0,
			PID_DATA1, PID_ACK, PID_NAK, PID_STALL:
				pid_legal = 1'b1;
			default:
				pid_legal = 1'b0;
		endcase
	end

	// Check nibble is the complement of the PID
	assign pid_ok = pid_legal && (rx_byte[7:4] == ~rx_byte[3:0]);

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
		begin
			state      <= ST_IDLE;
			receiving  <= 1'b0;
			push_valid <= 1'b0;
			err_pulse  <= 1'b0;
			pkt_done   <= 1'b0;
		end
		else
		begin
			push_valid <= 1'b0;
			err_pulse  <= 1'b0;
			pkt_done   <= 1'b0;
			case (state)
				ST_IDLE:
					if (evt.d_edge && !evt.eop)
					begin
						state     <= ST_SYNC;
						receiving <= 1'b1;
					end
				ST_SYNC, ST_PID:
					if (evt.eop)
					begin
						state     <= ST_ERROR;
						receiving <= 1'b0;
						err_pulse <= 1'b1;
					end
					else if (byte_received)
					begin
						if (state == ST_SYNC && rx_byte == SYNC_BYTE)
							state <= ST_PID;
						else if (state == ST_PID && pid_ok && !full)
						begin
							state      <= ST_DATA;
							push_valid <= 1'b1;
						end
						else
						begin
							state     <= ST_ERROR;
							receiving <= 1'b0;
							err_pulse <= 1'b1;
						end
					end
				ST_DATA:
					if (evt.eop)
					begin
						state     <= ST_DONE;
						receiving <= 1'b0;
						pkt_done  <= 1'b1;
					end
					else if (byte_received)
					begin
						// Overflow drops the byte and ends the packet
						if (full)
						begin
							state     <= ST_ERROR;
							receiving <= 1'b0;
							err_pulse <= 1'b1;
						end
						else
							push_valid <= 1'b1;
					end
				ST_DONE:
					if (!evt.eop)
						state <= ST_IDLE;
				ST_ERROR:
					// Ignore the rest of the packet until SE0
					if (evt.eop)
						state <= ST_DONE;
				default:
				begin
					state     <= ST_IDLE;
					receiving <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (byte_received)
		begin
			push_entry.data   <= rx_byte;
			push_entry.is_pid <= (state == ST_PID);
		end
	end

	no_push_when_full: assert property (@(posedge clk) disable iff (!n_rst)
		push_valid |-> !full);

endmodule

// File: rtl/usb_rx_fifo_apb.sv
// ==============================
// Receive FIFO with APB slave for
// status, data and count
// ==============================
`timescale 1ns/1ps

module usb_rx_fifo_apb
	import usb_rx_pkg::*;
#(
	parameter int FIFO_DEPTH = 16
)
(
	input  logic        clk,
	input  logic        n_rst,
	input  rx_entry_t   push_entry,
	input  logic        push_valid,
	input  logic        err_pulse,
	input  logic        pkt_done,
	output logic        full,
	input  logic [7:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam logic [AW-1:0] LAST_SLOT = AW'(FIFO_DEPTH - 1);

	rx_entry_t     mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          empty;
	logic          access;
	logic          addr_ok;
	logic          push;
	logic          pop;
	logic          status_wr;
	logic          done_flag;
	logic          err_flag;

	assign empty = (count == '0);
	assign full  = (count == (AW+1)'(FIFO_DEPTH));

	// APB access phase, no wait states
	assign access    = psel && penable;
	assign addr_ok   = paddr inside {STATUS_ADDR, DATA_ADDR, COUNT_ADDR};
	assign push      = push_valid && !full;
	assign pop       = access && !pwrite && (paddr == DATA_ADDR) && !empty;
	assign status_wr = access && pwrite && (paddr == STATUS_ADDR);

	assign pready  = 1'b1;
	assign pslverr = access && (!addr_ok || (pwrite && paddr == DATA_ADDR));

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_entry;
	end

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Sticky flags, a new event wins over a clear in the same cycle
	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
		begin
			done_flag <= 1'b0;
			err_flag  <= 1'b0;
		end
		else
		begin
			if (pkt_done)
				done_flag <= 1'b1;
			else if (status_wr && pwdata[1])
				done_flag <= 1'b0;
			if (err_pulse)
				err_flag <= 1'b1;
			else if (status_wr && pwdata[2])
				err_flag <= 1'b0;
		end
	end

	always_comb
	begin
		prdata = '0;
		if (access && !pwrite)
		begin
			case (paddr)
				STATUS_ADDR:
					prdata = {29'd0, err_flag, done_flag, !empty};
				DATA_ADDR:
					if (!empty)
						prdata = {23'd0, mem[rd_ptr]};
				COUNT_ADDR:
					prdata = {{(31 - AW){1'b0}}, count};
				default:
					prdata = '0;
			endcase
		end
	end

endmodule

// File: rtl/usb_rx_top.sv
// ==============================
// USB full-speed receive path top
// ==============================
`timescale 1ns/1ps

module usb_rx_top
	import usb_rx_pkg::*;
#(
	parameter int CLKS_PER_BIT = 8,
	parameter int FIFO_DEPTH   = 16
)
(
	input  logic        clk,
	input  logic        n_rst,
	input  logic        d_plus,
	input  logic        d_minus,
	input  logic [7:0]  paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	line_evt_t  evt;
	logic       receiving;
	logic       shift_enable;
	logic       rx_hold;
	logic       byte_received;
	logic [7:0] rx_byte;
	rx_entry_t  push_entry;
	logic       push_valid;
	logic       err_pulse;
	logic       pkt_done;
	logic       full;

	usb_line_sync usb_line_sync_inst (
		.clk     (clk),
		.n_rst   (n_rst),
		.d_plus  (d_plus),
		.d_minus (d_minus),
		.evt     (evt)
	);

	usb_rx_timer #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) usb_rx_timer_inst (
		.clk           (clk),
		.n_rst         (n_rst),
		.evt           (evt),
		.receiving     (receiving),
		.shift_enable  (shift_enable),
		.rx_hold       (rx_hold),
		.byte_received (byte_received)
	);

	usb_rx_shifter usb_rx_shifter_inst (
		.clk          (clk),
		.n_rst        (n_rst),
		.evt          (evt),
		.shift_enable (shift_enable),
		.rx_hold      (rx_hold),
		.receiving    (receiving),
		.rx_byte      (rx_byte)
	);

	usb_rx_ctrl usb_rx_ctrl_inst (
		.clk           (clk),
		.n_rst         (n_rst),
		.evt           (evt),
		.byte_received (byte_received),
		.rx_byte       (rx_byte),
		.full          (full),
		.receiving     (receiving),
		.push_entry    (push_entry),
		.push_valid    (push_valid),
		.err_pulse     (err_pulse),
		.pkt_done      (pkt_done)
	);

	usb_rx_fifo_apb #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) usb_rx_fifo_apb_inst (
		.clk        (clk),
		.n_rst      (n_rst),
		.push_entry (push_entry),
		.push_valid (push_valid),
		.err_pulse  (err_pulse),
		.pkt_done   (pkt_done),
		.full       (full),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr)
	);

endmodule

// File: bench/usb_bus_driver.svh
// ==============================
// NRZI packet driver with bit
// stuffing, APB read and write
// ==============================
`ifndef USB_BUS_DRIVER_SVH
`define USB_BUS_DRIVER_SVH

// Hold one line state for a full bit period
task automatic drive_line(input logic dp, input logic dm);
	d_plus  = dp;
	d_minus = dm;
	repeat (CLKS_PER_BIT) @(negedge clk);
endtask

// A zero toggles the line and six ones in a row force a stuffed zero
task automatic send_bit(input logic b);
	if (!b)
		line_lvl = !line_lvl;
	drive_line(line_lvl, !line_lvl);
	if (!b)
		ones_run = 0;
	else
	begin
		ones_run++;
		if (ones_run == 6)
		begin
			ones_run = 0;
			line_lvl = !line_lvl;
			drive_line(line_lvl, !line_lvl);
		end
	end
endtask

// LSB goes out first
task automatic send_byte(input logic [7:0] value);
	for (int i = 0; i < 8; i++)
		send_bit(value[i]);
endtask

// Sync, PID and payload, then two bits of SE0 and back to J
task automatic send_packet(input logic [7:0] sync, input logic [7:0] pid, input bit record);
	line_lvl = 1'b1;
	ones_run = 0;
	if (record)
		exp_q.push_back({1'b1, pid});
	@(negedge clk);
	send_byte(sync);
	send_byte(pid);
	foreach (payload[i])
	begin
		send_byte(payload[i]);
		if (record)
			exp_q.push_back({1'b0, payload[i]});
	end
	drive_line(1'b0, 1'b0);
	drive_line(1'b0, 1'b0);
	line_lvl = 1'b1;
	drive_line(1'b1, 1'b0);
endtask

// Setup phase, access phase, then idle
task automatic read_reg(
	input  logic [7:0]  addr,
	input  bit          compare,
	input  logic [31:0] expected,
	output logic [31:0] value
);
	@(negedge clk);
	paddr      = addr;
	pwrite     = 1'b0;
	psel       = 1'b1;
	penable    = 1'b0;
	check_rd   = compare;
	exp_rd     = expected;
	exp_slverr = !(addr inside {STATUS_ADDR, DATA_ADDR, COUNT_ADDR});
	@(negedge clk);
	penable = 1'b1;
	@(negedge clk);
	psel     = 1'b0;
	penable  = 1'b0;
	check_rd = 1'b0;
	value    = rd_capture;
endtask

task automatic write_reg(input logic [7:0] addr, input logic [31:0] value);
	@(negedge clk);
	paddr      = addr;
	pwrite     = 1'b1;
	pwdata     = value;
	psel       = 1'b1;
	penable    = 1'b0;
	exp_slverr = !(addr inside {STATUS_ADDR, DATA_ADDR, COUNT_ADDR}) || addr == DATA_ADDR;
	@(negedge clk);
	penable = 1'b1;
	@(negedge clk);
	psel    = 1'b0;
	penable = 1'b0;
	pwrite  = 1'b0;
endtask

`endif

// File: bench/usb_rx_tb.sv
// ==============================
// Testbench for the USB receive
// path, APB checks and report
// ==============================
`timescale 1ns/1ps

module usb_rx_tb
	import usb_rx_pkg::*;
();

	localparam int CLKS_PER_BIT = 8;
	localparam int FIFO_DEPTH   = 16;
	localparam int POLL_LIMIT   = 200;

	logic        clk;
	logic        n_rst;
	logic        d_plus;
	logic        d_minus;
	logic [7:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	// Scoreboard and checker state
	logic [8:0]  exp_q[$];
	logic [7:0]  payload[$];
	logic [31:0] exp_rd;
	logic        check_rd;
	logic        exp_slverr;
	logic [31:0] rd_capture;
	logic [31:0] rd_discard;
	logic        line_lvl;
	int          ones_run;
	int          check_errs;
	int          timeouts;
	int          errs_before;
	int          test_count;
	int          test_fails;

	`include "usb_bus_driver.svh"

	usb_rx_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.FIFO_DEPTH   (FIFO_DEPTH)
	) usb_rx_top_inst (
		.clk     (clk),
		.n_rst   (n_rst),
		.d_plus  (d_plus),
		.d_minus (d_minus),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Read data as it stood in the access phase
	always_ff @(posedge clk)
	begin
		if (psel && penable)
			rd_capture <= prdata;
	end

	read_value_ok: assert property (@(posedge clk) disable iff (!n_rst)
		(psel && penable && !pwrite && check_rd) |-> (prdata == exp_rd))
	else
	begin
		$display("CHECK FAILED t=%0t prdata at addr %h expected=%h actual=%h",
			$time, $sampled(paddr), $sampled(exp_rd), $sampled(prdata));
		check_errs++;
	end

	slverr_ok: assert property (@(posedge clk) disable iff (!n_rst)
		pslverr == (psel && penable && exp_slverr))
	else
	begin
		$display("CHECK FAILED t=%0t pslverr at addr %h expected=%b actual=%b",
			$time, $sampled(paddr), $sampled(psel && penable && exp_slverr),
			$sampled(pslverr));
		check_errs++;
	end

	pready_high: assert property (@(posedge clk) pready)
	else
	begin
		$display("CHECK FAILED t=%0t pready expected=1 actual=%b", $time, $sampled(pready));
		check_errs++;
	end

	// Check nibble sits above the PID code
	function automatic logic [7:0] pid_byte(input usb_pid_e pid);
		return {~pid, pid};
	endfunction

	task automatic check_reg(input logic [7:0] addr, input logic [31:0] expected);
		logic [31:0] value;
		read_reg(addr, 1'b1, expected, value);
	endtask

	// Empty queue means the FIFO should return 0
	task automatic pop_entry();
		logic [31:0] expected;
		expected = '0;
		if (exp_q.size() > 0)
			expected = {23'd0, exp_q.pop_front()};
		check_reg(DATA_ADDR, expected);
	endtask

	task automatic drain_fifo();
		while (exp_q.size() > 0)
			pop_entry();
	endtask

	task automatic wait_status(input logic [31:0] mask);
		logic [31:0] status;
		int          polls;
		status = '0;
		polls  = 0;
		while ((status & mask) == '0 && polls < POLL_LIMIT)
		begin
			read_reg(STATUS_ADDR, 1'b0, '0, status);
			polls++;
		end
		if ((status & mask) == '0)
		begin
			$display("Timed out after %0d polls waiting for STATUS mask %h", polls, mask);
			timeouts++;
		end
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (check_errs + timeouts == errs_before)
			$display("test %0d %s: passed", test_count, name);
		else
		begin
			test_fails++;
			$display("test %0d %s: %0d errors", test_count, name,
				check_errs + timeouts - errs_before);
		end
		errs_before = check_errs + timeouts;
	endtask

	initial
	begin
		void'($urandom(86267));
		n_rst       = 1'b0;
		d_plus      = 1'b1;
		d_minus     = 1'b0;
		paddr       = '0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		pwdata      = '0;
		exp_rd      = '0;
		check_rd    = 1'b0;
		exp_slverr  = 1'b0;
		line_lvl    = 1'b1;
		ones_run    = 0;
		check_errs  = 0;
		timeouts    = 0;
		errs_before = 0;
		test_count  = 0;
		test_fails  = 0;
		repeat (5) @(negedge clk);
		n_rst = 1'b1;

		check_reg(STATUS_ADDR, 32'h0);
		check_reg(COUNT_ADDR, 32'h0);
		finish_test("reset values");

		repeat (4)
			payload.push_back(8'($urandom));
		send_packet(SYNC_BYTE, pid_byte(PID_DATA0), 1'b1);
		wait_status(32'h2);
		check_reg(COUNT_ADDR, 32'(exp_q.size()));
		check_reg(STATUS_ADDR, 32'h3);
		drain_fifo();
		write_reg(STATUS_ADDR, 32'h2);
		check_reg(STATUS_ADDR, 32'h0);
		finish_test("data0 packet");

		// Long runs of ones need stuffed zeros
		payload = '{8'hFF, 8'hFF, 8'h3F, 8'hFE};
		send_packet(SYNC_BYTE, pid_byte(PID_DATA1), 1'b1);
		wait_status(32'h2);
		check_reg(COUNT_ADDR, 32'(exp_q.size()));
		drain_fifo();
		write_reg(STATUS_ADDR, 32'h2);
		check_reg(STATUS_ADDR, 32'h0);
		finish_test("bit stuffing");

		payload = '{8'($urandom), 8'($urandom)};
		send_packet(SYNC_BYTE, {PID_DATA1, PID_DATA1}, 1'b0);
		wait_status(32'h4);
		check_reg(COUNT_ADDR, 32'h0);
		check_reg(STATUS_ADDR, 32'h4);
		write_reg(STATUS_ADDR, 32'h4);
		check_reg(STATUS_ADDR, 32'h0);
		finish_test("bad pid");

		send_packet(8'hC0, pid_byte(PID_DATA0), 1'b0);
		wait_status(32'h4);
		check_reg(COUNT_ADDR, 32'h0);
		check_reg(STATUS_ADDR, 32'h4);
		write_reg(STATUS_ADDR, 32'h4);
		finish_test("bad sync");

		payload = '{8'($urandom), 8'($urandom)};
		send_packet(SYNC_BYTE, pid_byte(PID_DATA1), 1'b1);
		wait_status(32'h2);
		read_reg(8'h0C, 1'b0, '0, rd_discard);
		write_reg(DATA_ADDR, 32'h1AA);
		check_reg(COUNT_ADDR, 32'(exp_q.size()));
		drain_fifo();
		pop_entry();
		write_reg(STATUS_ADDR, 32'h2);
		check_reg(STATUS_ADDR, 32'h0);
		finish_test("apb errors");

		$display("tests run %0d, tests failed %0d, check errors %0d, timeouts %0d",
			test_count, test_fails, check_errs, timeouts);
		if (check_errs + timeouts == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: files.f
+incdir+bench
common/usb_rx_pkg.sv
rtl/usb_line_sync.sv
usb_timer/usb_rx_timer.sv
rtl/usb_rx_shifter.sv
rtl/usb_rx_ctrl.sv
rtl/usb_rx_fifo_apb.sv
rtl/usb_rx_top.sv
bench/usb_rx_tb.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
TOP        := usb_rx_tb
FILELIST   := files.f
OBJ_DIR    := obj_dir
PASS_MSG   := PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
